/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = icache_tb
RTL_TOP  = icache_top
FILELIST = verilog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/icache_patterns.txt */
// column 1: fetch byte address (hex, word aligned)
// column 2: 1 if this fetch must start a line refill, 0 for a hit; ffffffff ends the list
00001000 1
00001004 0
0000100c 0
00001008 0
00002008 1
00001004 0
00001010 1
00002000 0
00003000 1
0000300c 0
00004004 1
00001014 0
00001008 0
00005000 1
00002000 1
00001000 0
00004008 0
00003004 1
0000500c 0
00002004 1
00001004 1
00003008 0
00005004 0
0000101c 0
00001020 1
00001030 1
00001024 0
0000103c 0
00004000 1
00002000 1
ffffffff 0

/* bench/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;

    localparam int          max_records = 64;
    localparam int          wait_limit  = 200;
    localparam logic [31:0] data_key    = 32'h5a5a0000;
    localparam logic [31:0] end_marker  = 32'hffffffff;

    logic        clk;
    logic        resetn;
    logic        req;
    logic [31:0] addr;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] data;
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic        mem_okay;
    logic        mem_last;
    logic [31:0] mem_rdata;

    // address and refill flag alternate
    logic [31:0] patterns [2*max_records];

    integer      seed;
    integer      errors;
    integer      tests;
    integer      refill_count;
    integer      early_restarts;
    integer      hits_under_miss;
    integer      serialized;
    logic        refill_active;
    logic [31:0] refill_addr;
    logic        prev_accept;
    logic [31:0] prev_addr;

    icache_top i_icache_top (
        .clk       (clk),
        .resetn    (resetn),
        .req       (req),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .data      (data),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_okay  (mem_okay),
        .mem_last  (mem_last),
        .mem_rdata (mem_rdata)
    );

    always #2 clk = ~clk;

    task automatic drive_point();
        @(posedge clk);
        #0.5;
    endtask

    // response one cycle after every accepted fetch
    always @(negedge clk) begin
        if (resetn) begin
            prev_accept = 1'b0;
            if (data_ok === 1'b1 || mem_valid === 1'b1) begin
                $display("Mismatch at %0t: data_ok or mem_valid active during reset", $time);
                errors = errors + 1;
            end
        end else begin
            if (data_ok && !prev_accept) begin
                $display("Error at %0t: data_ok without a fetch accepted the cycle before", $time);
                errors = errors + 1;
            end else if (prev_accept && !data_ok) begin
                $display("Error at %0t: no data_ok one cycle after fetch %h", $time, prev_addr);
                errors = errors + 1;
            end else if (data_ok && data !== (prev_addr ^ data_key)) begin
                $display("Mismatch at %0t: data %h for fetch %h, expected %h",
                         $time, data, prev_addr, prev_addr ^ data_key);
                errors = errors + 1;
            end
            prev_accept = req && addr_ok;
            prev_addr   = addr;
        end
    end

    // memory model returns four beats in wrap order from the critical word
    initial begin : memory_model
        integer     gap;
        integer     w;
        logic [1:0] beat_off;
        mem_okay  = 1'b0;
        mem_last  = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            refill_active = 1'b0;
            if (!resetn && mem_valid) begin
                refill_count  = refill_count + 1;
                refill_addr   = mem_addr;
                refill_active = 1'b1;
                for (w = 0; w < 4; w++) begin
                    gap = $unsigned($random(seed)) % 4;
                    drive_point();
                    mem_okay = 1'b0;
                    mem_last = 1'b0;
                    repeat (gap) drive_point();
                    beat_off  = refill_addr[3:2] + 2'(w);
                    mem_okay  = 1'b1;
                    mem_last  = (w == 3);
                    mem_rdata = {refill_addr[31:4], beat_off, 2'b00} ^ data_key;
                    @(negedge clk);
                    if (!mem_valid || mem_addr !== refill_addr) begin
                        $display("Error at %0t: memory request changed before the last beat",
                                 $time);
                        errors = errors + 1;
                    end
                end
                drive_point();
                mem_okay = 1'b0;
                mem_last = 1'b0;
            end
        end
    end

    // one fetch held until addr_ok
    // entered and left at a drive point
    task automatic run_fetch(input integer num, input logic [31:0] fa,
                             input logic expect_refill, output logic stalled);
        integer waited;
        integer count_before;
        integer errors_before;
        logic   under_refill;
        logic   accepted;
        errors_before = errors;
        count_before  = refill_count;
        under_refill  = refill_active && (fa[31:4] == refill_addr[31:4]);
        if (refill_active && expect_refill)
            serialized = serialized + 1;
        if (refill_active && !expect_refill && !under_refill)
            hits_under_miss = hits_under_miss + 1;
        req      = 1'b1;
        addr     = fa;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < wait_limit) begin
            @(negedge clk);
            if (addr_ok)
                accepted = 1'b1;
            else
                waited = waited + 1;
        end
        drive_point();
        req     = 1'b0;
        stalled = !accepted;
        if (!accepted) begin
            $display("Error at %0t: fetch %h not accepted within %0d cycles",
                     $time, fa, wait_limit);
            errors = errors + 1;
        end else if (expect_refill) begin
            if (refill_count != count_before + 1) begin
                $display("Error at %0t: fetch %h did not start one refill", $time, fa);
                errors = errors + 1;
            end else if (refill_addr !== fa) begin
                $display("Mismatch at %0t: refill address %h, expected critical word %h",
                         $time, refill_addr, fa);
                errors = errors + 1;
            end else if (!refill_active) begin
                $display("Error at %0t: fetch %h waited for the whole line", $time, fa);
                errors = errors + 1;
            end else begin
                early_restarts = early_restarts + 1;
            end
        end else if (refill_count != count_before) begin
            $display("Error at %0t: fetch %h started a refill on a hit", $time, fa);
            errors = errors + 1;
        end else if (!under_refill && waited != 0) begin
            $display("Error at %0t: hit %h stalled %0d cycles", $time, fa, waited);
            errors = errors + 1;
        end
        tests = tests + 1;
        $display("fetch %0d addr %h refill %0d waited %0d: %s", num, fa, expect_refill,
                 waited, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin : main
        integer n;
        integer waited;
        integer expected_refills;
        integer errors_before;
        logic   timed_out;
        clk = 1'b0;
        resetn = 1'b1;
        req = 1'b0;
        addr = '0;
        seed = 99;
        errors = 0;
        tests = 0;
        refill_count = 0;
        early_restarts = 0;
        hits_under_miss = 0;
        serialized = 0;
        refill_active = 1'b0;
        refill_addr = '0;
        expected_refills = 0;
        timed_out = 1'b0;
        $readmemh("bench/icache_patterns.txt", patterns);
        repeat (4) @(posedge clk);
        #0.5;
        resetn = 1'b0;

        // nothing may move while idle after reset
        errors_before = errors;
        repeat (3) begin
            @(negedge clk);
            if (addr_ok !== 1'b0 || data_ok !== 1'b0 || mem_valid !== 1'b0) begin
                $display("Mismatch at %0t: cache outputs active while idle after reset", $time);
                errors = errors + 1;
            end
        end
        tests = tests + 1;
        $display("test reset: %s", (errors == errors_before) ? "ok" : "failed");

        drive_point();
        n = 0;
        while (!timed_out && n < max_records && patterns[2*n] !== end_marker) begin
            expected_refills = expected_refills + ((patterns[2*n+1] != 0) ? 1 : 0);
            run_fetch(n, patterns[2*n], patterns[2*n+1] != 0, timed_out);
            n = n + 1;
        end

        // let the last refill and response drain
        waited = 0;
        while (refill_active && waited < wait_limit) begin
            drive_point();
            waited = waited + 1;
        end
        repeat (2) drive_point();
        errors_before = errors;
        if (refill_active) begin
            $display("Error at %0t: refill still running at the end", $time);
            errors = errors + 1;
        end
        if (refill_count != expected_refills) begin
            $display("Mismatch at %0t: %0d refills, expected %0d",
                     $time, refill_count, expected_refills);
            errors = errors + 1;
        end
        if (hits_under_miss == 0 || serialized == 0) begin
            $display("Error: no hit under miss or no serialized miss was seen");
            errors = errors + 1;
        end
        tests = tests + 1;
        $display("test refill totals: %s", (errors == errors_before) ? "ok" : "failed");
        $display("tests %0d, errors %0d, refills %0d, early restarts %0d, hits under miss %0d, %s%0d",
                 tests, errors, refill_count, early_restarts, hits_under_miss,
                 "serialized misses ", serialized);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/icache_pkg.sv
verilog/refill_if.sv
verilog/icache_lookup.sv
verilog/icache_refill_fsm.sv
verilog/icache_refill_counter.sv
verilog/icache_data_array.sv
verilog/icache_top.sv
bench/icache_tb.sv

/* verilog/icache_data_array.sv */
`timescale 1ns/10ps

module icache_data_array #(
    parameter int index_bits  = 2,
    parameter int offset_bits = 2
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             rd_en,
    input  logic [icache_pkg::way_bits-1:0]  rd_way,
    input  logic [index_bits-1:0]            rd_index,
    input  logic [offset_bits-1:0]           rd_offset,
    input  logic [icache_pkg::word_bits-1:0] mem_rdata,
    output logic                             data_ok,
    output logic [icache_pkg::word_bits-1:0] data,
    refill_if.data                           refill
);
    localparam int pos_bits = icache_pkg::way_bits + index_bits + offset_bits;
    localparam int depth    = 2 ** pos_bits;

    // flat word storage addressed by {way, index, offset}
    logic [icache_pkg::word_bits-1:0] mem [depth];

    logic [pos_bits-1:0] rd_pos;
    logic [pos_bits-1:0] wr_pos;

    assign rd_pos = {rd_way, rd_index, rd_offset};
    assign wr_pos = {refill.line_way, refill.line_index, refill.beat_offset};

    always_ff @(posedge clk) begin
        if (refill.beat_write) begin
            mem[wr_pos] <= mem_rdata;
        end
        if (rd_en) begin
            data <= mem[rd_pos];
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= rd_en;
        end
    end

endmodule

/* verilog/icache_lookup.sv */
`timescale 1ns/10ps

module icache_lookup #(
    parameter int index_bits  = 2,
    parameter int offset_bits = 2
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             req,
    input  logic [icache_pkg::addr_bits-1:0] addr,
    input  logic                             mem_last,
    output logic                             addr_ok,
    output logic [icache_pkg::way_bits-1:0]  hit_way,
    refill_if.lookup                         refill
);
    localparam int num_sets = 2 ** index_bits;
    localparam int tag_bits = icache_pkg::addr_bits - index_bits - offset_bits - 2;

    // per-set metadata
    logic [icache_pkg::num_ways-1:0]  valid [num_sets];
    logic [tag_bits-1:0]              tags  [num_sets][icache_pkg::num_ways];
    logic [icache_pkg::plru_bits-1:0] plru  [num_sets];

    // address fields
    logic [tag_bits-1:0]    req_tag;
    logic [index_bits-1:0]  req_index;
    logic [offset_bits-1:0] req_offset;

    assign req_offset = addr[offset_bits+1:2];
    assign req_index  = addr[index_bits+offset_bits+1:offset_bits+2];
    assign req_tag    = addr[icache_pkg::addr_bits-1:index_bits+offset_bits+2];

    logic [icache_pkg::num_ways-1:0]  hit_bits;
    logic                             hit;
    logic [icache_pkg::plru_bits-1:0] cur_plru;
    logic [icache_pkg::plru_bits-1:0] next_plru;
    logic [icache_pkg::way_bits-1:0]  victim;
    logic                             in_refill;
    logic                             word_ready;

    // compare all four ways
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < icache_pkg::num_ways; i++) begin
            hit_bits[i] = valid[req_index][i] && (tags[req_index][i] == req_tag);
            if (hit_bits[i]) begin
                hit_way = icache_pkg::way_bits'(i);
            end
        end
    end

    assign hit = |hit_bits;

    // plru tree: bit 0 is the root, bit 1 covers ways 0/1, bit 2 covers ways 2/3
    assign cur_plru = plru[req_index];
    assign victim   = cur_plru[0] ? {1'b1, cur_plru[2]} : {1'b0, cur_plru[1]};

    // point every node on the path away from the way just used
    always_comb begin
        next_plru    = cur_plru;
        next_plru[0] = ~hit_way[1];
        if (hit_way[1]) begin
            next_plru[2] = ~hit_way[0];
        end else begin
            next_plru[1] = ~hit_way[0];
        end
    end

    // line under refill: only words already written may be read
    assign in_refill  = refill.busy && (refill.line_tag == req_tag) &&
                        (refill.line_index == req_index);
    assign word_ready = !in_refill || refill.ready_mask[req_offset];

    assign addr_ok = req && hit && word_ready;

    // a new miss may start once the refill port is free or freeing up
    assign refill.start        = req && !hit && (!refill.busy || mem_last);
    assign refill.start_tag    = req_tag;
    assign refill.start_index  = req_index;
    assign refill.start_way    = victim;
    assign refill.start_offset = req_offset;

    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
                plru[s]  <= '0;
            end
        end else begin
            if (addr_ok) begin
                plru[req_index] <= next_plru;
            end
            if (refill.start) begin
                valid[req_index][victim] <= 1'b1;
            end
        end
    end

    // victim tag is claimed at once, before any data arrives
    always_ff @(posedge clk) begin
        if (refill.start) begin
            tags[req_index][victim] <= req_tag;
        end
    end

endmodule

/* verilog/icache_pkg.sv */
package icache_pkg;

    // instruction and memory word
    parameter int word_bits = 32;

    // fixed 4-way organization
    parameter int num_ways = 4;
    parameter int way_bits = 2;

    // tree pseudo-LRU, one bit per inner node
    parameter int plru_bits = 3;

    parameter int addr_bits = 32;

    // refill state machine
    typedef enum logic {
        refill_idle = 1'b0,
        refill_busy = 1'b1
    } refill_state_t;

endpackage

/* verilog/icache_refill_counter.sv */
`timescale 1ns/10ps

module icache_refill_counter #(
    parameter int index_bits  = 2,
    parameter int offset_bits = 2
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       mem_okay,
    refill_if.counter  refill
);
    localparam int line_words = 2 ** offset_bits;

    // a beat only counts while a refill is open
    assign refill.beat_write = mem_okay && refill.busy;

    always_ff @(posedge clk) begin
        if (resetn) begin
            refill.beat_offset <= '0;
            refill.ready_mask  <= '0;
        end else if (refill.start) begin
            // new line restarts at its critical word
            refill.beat_offset <= refill.start_offset;
            refill.ready_mask  <= '0;
        end else if (refill.beat_write) begin
            for (int w = 0; w < line_words; w++) begin
                if (refill.beat_offset == offset_bits'(w)) begin
                    refill.ready_mask[w] <= 1'b1;
                end
            end
            // natural wrap within the line
            refill.beat_offset <= refill.beat_offset + 1'b1;
        end
    end

endmodule

/* verilog/icache_refill_fsm.sv */
`timescale 1ns/10ps

module icache_refill_fsm #(
    parameter int index_bits  = 2,
    parameter int offset_bits = 2
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             mem_okay,
    input  logic                             mem_last,
    output logic                             mem_valid,
    output logic [icache_pkg::addr_bits-1:0] mem_addr,
    refill_if.fsm                            refill
);
    icache_pkg::refill_state_t state;
    icache_pkg::refill_state_t state_next;

    logic last_beat;

    assign last_beat = mem_okay && mem_last;

    always_comb begin
        state_next = state;
        case (state)
            icache_pkg::refill_idle: begin
                if (refill.start) begin
                    state_next = icache_pkg::refill_busy;
                end
            end
            icache_pkg::refill_busy: begin
                // back-to-back miss keeps the machine busy
                if (last_beat && !refill.start) begin
                    state_next = icache_pkg::refill_idle;
                end
            end
            default: begin
                state_next = icache_pkg::refill_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= icache_pkg::refill_idle;
        end else begin
            state <= state_next;
        end
    end

    // latch the miss line and the critical word address
    always_ff @(posedge clk) begin
        if (refill.start) begin
            refill.line_tag   <= refill.start_tag;
            refill.line_index <= refill.start_index;
            refill.line_way   <= refill.start_way;
            mem_addr <= {refill.start_tag, refill.start_index, refill.start_offset, 2'b00};
        end
    end

    assign refill.busy = (state == icache_pkg::refill_busy);
    assign mem_valid   = refill.busy;

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/10ps

module icache_top #(
    parameter int index_bits  = 2,
    parameter int offset_bits = 2
) (
    input  logic                             clk,
    input  logic                             resetn,

    // fetch side
    input  logic                             req,
    input  logic [icache_pkg::addr_bits-1:0] addr,
    output logic                             addr_ok,
    output logic                             data_ok,
    output logic [icache_pkg::word_bits-1:0] data,

    // memory read port
    output logic                             mem_valid,
    output logic [icache_pkg::addr_bits-1:0] mem_addr,
    input  logic                             mem_okay,
    input  logic                             mem_last,
    input  logic [icache_pkg::word_bits-1:0] mem_rdata
);
    logic [icache_pkg::way_bits-1:0] hit_way;
    logic                            accept;

    assign accept = req && addr_ok;

    refill_if #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) refill ();

    icache_lookup #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_icache_lookup (
        .clk      (clk),
        .resetn   (resetn),
        .req      (req),
        .addr     (addr),
        .mem_last (mem_last),
        .addr_ok  (addr_ok),
        .hit_way  (hit_way),
        .refill   (refill.lookup)
    );

    icache_refill_fsm #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_icache_refill_fsm (
        .clk       (clk),
        .resetn    (resetn),
        .mem_okay  (mem_okay),
        .mem_last  (mem_last),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .refill    (refill.fsm)
    );

    icache_refill_counter #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_icache_refill_counter (
        .clk      (clk),
        .resetn   (resetn),
        .mem_okay (mem_okay),
        .refill   (refill.counter)
    );

    // read address comes straight from the fetch address
    icache_data_array #(
        .index_bits  (index_bits),
        .offset_bits (offset_bits)
    ) i_icache_data_array (
        .clk       (clk),
        .resetn    (resetn),
        .rd_en     (accept),
        .rd_way    (hit_way),
        .rd_index  (addr[index_bits+offset_bits+1:offset_bits+2]),
        .rd_offset (addr[offset_bits+1:2]),
        .mem_rdata (mem_rdata),
        .data_ok   (data_ok),
        .data      (data),
        .refill    (refill.data)
    );

endmodule

/* verilog/refill_if.sv */
`timescale 1ns/10ps

interface refill_if #(
    parameter int index_bits  = 2,
    parameter int offset_bits = 2
);
    localparam int tag_bits   = icache_pkg::addr_bits - index_bits - offset_bits - 2;
    localparam int line_words = 2 ** offset_bits;

    // new miss, from the lookup
    logic                             start;
    logic [tag_bits-1:0]              start_tag;
    logic [index_bits-1:0]            start_index;
    logic [icache_pkg::way_bits-1:0]  start_way;
    logic [offset_bits-1:0]           start_offset;

    // line currently being filled
    logic                             busy;
    logic [tag_bits-1:0]              line_tag;
    logic [index_bits-1:0]            line_index;
    logic [icache_pkg::way_bits-1:0]  line_way;

    // beat progress
    logic [offset_bits-1:0]           beat_offset;
    logic [line_words-1:0]            ready_mask;
    logic                             beat_write;

    modport lookup (
        output start, start_tag, start_index, start_way, start_offset,
        input  busy, line_tag, line_index, ready_mask
    );

    modport fsm (
        input  start, start_tag, start_index, start_way, start_offset,
        output busy, line_tag, line_index, line_way
    );

    modport counter (
        input  start, start_offset, busy,
        output beat_offset, ready_mask, beat_write
    );

    modport data (
        input line_way, line_index, beat_offset, beat_write
    );

endinterface
